//--- include/usb4_codec_defs.svh
`ifndef USB4_CODEC_DEFS_SVH
`define USB4_CODEC_DEFS_SVH

// number of lanes carried side by side through the codec
`define USB4_LANES 2

// payload bytes in one block per lane
`define GEN2_BLOCK_BYTES 8
`define GEN3_BLOCK_BYTES 16

// 64b/66b sync header codes, sent in the two low bits of the lane word
`define GEN2_HDR_DATA 2'b10
`define GEN2_HDR_OS   2'b01

// 128b/132b sync header codes, sent in the four low bits of the lane word
`define GEN3_HDR_DATA 4'b1010
`define GEN3_HDR_OS   4'b0101

// in Gen4 a d_sel of this value marks the byte stream as ordered set
`define GEN4_OS_SEL 4'd8

// widest encoded lane word, a 4-bit header and 16 payload bytes
`define ENC_WORD_BITS 132

`endif

//--- verilog/usb4_link_pkg.sv
package usb4_link_pkg;

	// link generation as carried on gen_speed
	typedef enum logic [1:0] {
		GEN4 = 2'd0,
		GEN3 = 2'd1,
		GEN2 = 2'd2
	} gen_speed_t;

	// one byte on one lane
	typedef logic [7:0] lane_byte_t;

	// Gen4 data selector, compared against the ordered-set value
	typedef logic [3:0] os_sel_t;

endpackage

//--- verilog/usb4_block_pkg.sv
`include "usb4_codec_defs.svh"

package usb4_block_pkg;

	// Gen2 only drives the two low bits
	typedef logic [3:0] sync_hdr_t;

	// header in the low bits, payload bytes stacked above it
	typedef logic [`ENC_WORD_BITS-1:0] enc_word_t;

	// byte position inside a block, wide enough for 16
	typedef logic [4:0] byte_cnt_t;

	// lane_1 sits in the upper half so the lane vectors below index by lane number
	typedef struct packed {
		usb4_link_pkg::lane_byte_t lane_1;
		usb4_link_pkg::lane_byte_t lane_0;
	} lane_pair_t;

	typedef struct packed {
		enc_word_t lane_1;
		enc_word_t lane_0;
	} enc_pair_t;

	// indexable views of the pair structs for per-lane loops
	typedef usb4_link_pkg::lane_byte_t [`USB4_LANES-1:0] lane_vec_t;
	typedef enc_word_t [`USB4_LANES-1:0] enc_vec_t;

	typedef enum logic [1:0] {
		ALIGN_WAIT,
		ALIGN_FIRST,
		ALIGNED
	} dec_state_t;

	// width of the sync header in front of the payload
	function automatic logic [2:0] hdr_width(usb4_link_pkg::gen_speed_t gen);
		case (gen)
			usb4_link_pkg::GEN2: return 3'd2;
			usb4_link_pkg::GEN3: return 3'd4;
			default: return 3'd0;
		endcase
	endfunction

	// Gen4 is unblocked, so every byte is a block of one
	function automatic byte_cnt_t block_len(usb4_link_pkg::gen_speed_t gen);
		case (gen)
			usb4_link_pkg::GEN2: return byte_cnt_t'(`GEN2_BLOCK_BYTES);
			usb4_link_pkg::GEN3: return byte_cnt_t'(`GEN3_BLOCK_BYTES);
			default: return byte_cnt_t'(1);
		endcase
	endfunction

endpackage

//--- verilog/lane_block_encoder.sv
`timescale 1ns/1ns
`include "usb4_codec_defs.svh"

module lane_block_encoder (
	input  logic                       enc_clk,
	input  logic                       rst,
	input  logic                       codec_enable,
	input  usb4_link_pkg::gen_speed_t  gen_speed,
	input  usb4_block_pkg::lane_pair_t tx_bytes,
	input  logic                       tx_strobe,
	input  logic                       tx_os,
	output usb4_block_pkg::enc_pair_t  blk_words,
	output logic                       blk_strobe
);

	import usb4_link_pkg::*;
	import usb4_block_pkg::*;

	lane_vec_t in_vec;
	enc_vec_t  asm_vec;
	enc_vec_t  next_vec;
	enc_vec_t  blk_vec;

	byte_cnt_t   fill_cnt;
	logic        hdr_os;
	logic        blk_os;
	logic        last_byte;
	logic [2:0]  hdr_w;
	logic [7:0]  byte_off;
	sync_hdr_t   hdr_code;

	assign in_vec    = lane_vec_t'(tx_bytes);
	assign blk_words = enc_pair_t'(blk_vec);

	assign hdr_w     = hdr_width(gen_speed);
	assign byte_off  = {5'b00000, hdr_w} + {fill_cnt, 3'b000};
	assign last_byte = (fill_cnt == block_len(gen_speed) - byte_cnt_t'(1));

	// the first byte of a block decides its type, later bytes use the latched copy
	assign blk_os = (fill_cnt == '0) ? tx_os : hdr_os;

	always_comb begin
		if (gen_speed == GEN3) begin
			hdr_code = blk_os ? `GEN3_HDR_OS : `GEN3_HDR_DATA;
		end else begin
			hdr_code = {2'b00, (blk_os ? `GEN2_HDR_OS : `GEN2_HDR_DATA)};
		end
	end

	// lane word as it stands once the current byte is placed
	always_comb begin
		for (int l = 0; l < `USB4_LANES; l++) begin
			next_vec[l] = asm_vec[l];
			next_vec[l][byte_off +: 8] = in_vec[l];
			case (gen_speed)
				GEN2: next_vec[l][1:0] = hdr_code[1:0];
				GEN3: next_vec[l][3:0] = hdr_code;
				default: next_vec[l] = enc_word_t'(in_vec[l]);
			endcase
		end
	end

	always_ff @(posedge enc_clk or negedge rst) begin
		if (!rst) begin
			fill_cnt   <= '0;
			hdr_os     <= 1'b0;
			blk_strobe <= 1'b0;
		end else if (!codec_enable) begin
			fill_cnt   <= '0;
			blk_strobe <= 1'b0;
		end else begin
			blk_strobe <= 1'b0;
			if (tx_strobe) begin
				if (fill_cnt == '0) begin
					hdr_os <= tx_os;
				end
				if (last_byte) begin
					fill_cnt   <= '0;
					blk_strobe <= 1'b1;
				end else begin
					fill_cnt <= fill_cnt + byte_cnt_t'(1);
				end
			end
		end
	end

	// the last byte copies the finished lane words to the output register
	always_ff @(posedge enc_clk) begin
		if (codec_enable && tx_strobe) begin
			asm_vec <= next_vec;
			if (last_byte) begin
				blk_vec <= next_vec;
			end
		end
	end

	// the fill counter assumes one block length for the whole enabled period
	a_gen_static: assert property (
		@(posedge enc_clk) disable iff (!rst)
		codec_enable && $past(codec_enable) |-> $stable(gen_speed)
	);

endmodule

//--- verilog/lane_block_decoder.sv
`timescale 1ns/1ns
`include "usb4_codec_defs.svh"

module lane_block_decoder (
	input  logic                       enc_clk,
	input  logic                       rst,
	input  logic                       codec_enable,
	input  usb4_link_pkg::gen_speed_t  gen_speed,
	input  usb4_link_pkg::os_sel_t     d_sel,
	input  usb4_block_pkg::enc_pair_t  blk_words,
	input  logic                       blk_strobe,
	output usb4_block_pkg::lane_pair_t rx_bytes,
	output logic                       rx_strobe,
	output logic                       data_os,
	output logic                       deskew_enable
);

	import usb4_link_pkg::*;
	import usb4_block_pkg::*;

	enc_vec_t   in_vec;
	lane_vec_t  rx_vec;
	lane_byte_t blk_payload [`USB4_LANES][`GEN3_BLOCK_BYTES];
	lane_byte_t byte_mem    [`USB4_LANES][`GEN3_BLOCK_BYTES];

	byte_cnt_t  drain_cnt;
	byte_cnt_t  blk_len;
	logic [2:0] hdr_w;
	sync_hdr_t  rx_hdr;
	dec_state_t align_state;
	dec_state_t align_next;

	assign in_vec   = enc_vec_t'(blk_words);
	assign rx_bytes = lane_pair_t'(rx_vec);

	assign hdr_w   = hdr_width(gen_speed);
	assign blk_len = block_len(gen_speed);

	// lane 0 carries the header that classifies the block
	assign rx_hdr = in_vec[0][3:0];

	// unpack every payload byte from behind the header
	always_comb begin
		for (int l = 0; l < `USB4_LANES; l++) begin
			for (int i = 0; i < `GEN3_BLOCK_BYTES; i++) begin
				blk_payload[l][i] = in_vec[l][{5'b00000, hdr_w} + 8'(8 * i) +: 8];
			end
		end
	end

	// Gen4 needs two bytes before the lanes count as aligned
	always_comb begin
		align_next = align_state;
		case (align_state)
			ALIGN_WAIT: align_next = (gen_speed == GEN4) ? ALIGN_FIRST : ALIGNED;
			ALIGN_FIRST: align_next = ALIGNED;
			default: align_next = ALIGNED;
		endcase
	end

	assign deskew_enable = (align_state == ALIGNED);

	always_ff @(posedge enc_clk or negedge rst) begin
		if (!rst) begin
			drain_cnt   <= '0;
			rx_strobe   <= 1'b0;
			data_os     <= 1'b0;
			align_state <= ALIGN_WAIT;
		end else if (!codec_enable) begin
			drain_cnt   <= '0;
			rx_strobe   <= 1'b0;
			data_os     <= 1'b0;
			align_state <= ALIGN_WAIT;
		end else if (blk_strobe) begin
			// byte 0 leaves straight away, the rest drain from memory
			rx_strobe   <= 1'b1;
			drain_cnt   <= (blk_len > byte_cnt_t'(1)) ? byte_cnt_t'(1) : '0;
			align_state <= align_next;
			case (gen_speed)
				GEN2: begin
					if (rx_hdr[1:0] == `GEN2_HDR_DATA) begin
						data_os <= 1'b0;
					end else if (rx_hdr[1:0] == `GEN2_HDR_OS) begin
						data_os <= 1'b1;
					end
				end
				GEN3: begin
					if (rx_hdr == `GEN3_HDR_DATA) begin
						data_os <= 1'b0;
					end else if (rx_hdr == `GEN3_HDR_OS) begin
						data_os <= 1'b1;
					end
				end
				default: data_os <= (d_sel == `GEN4_OS_SEL);
			endcase
		end else if (drain_cnt != '0) begin
			rx_strobe <= 1'b1;
			if (drain_cnt == blk_len - byte_cnt_t'(1)) begin
				drain_cnt <= '0;
			end else begin
				drain_cnt <= drain_cnt + byte_cnt_t'(1);
			end
		end else begin
			rx_strobe <= 1'b0;
		end
	end

	always_ff @(posedge enc_clk) begin
		if (codec_enable) begin
			if (blk_strobe) begin
				for (int l = 0; l < `USB4_LANES; l++) begin
					for (int i = 0; i < `GEN3_BLOCK_BYTES; i++) begin
						byte_mem[l][i] <= blk_payload[l][i];
					end
					rx_vec[l] <= blk_payload[l][0];
				end
			end else if (drain_cnt != '0) begin
				for (int l = 0; l < `USB4_LANES; l++) begin
					rx_vec[l] <= byte_mem[l][drain_cnt[3:0]];
				end
			end
		end
	end

	// header widths and the Gen4 flag both depend on configuration held for the run
	a_cfg_static: assert property (
		@(posedge enc_clk) disable iff (!rst)
		codec_enable && $past(codec_enable) |-> $stable(gen_speed) && $stable(d_sel)
	);

	// the encoder needs a full block of strobes, so a new block never lands mid drain
	a_no_overlap: assert property (
		@(posedge enc_clk) disable iff (!rst)
		codec_enable && blk_strobe |-> drain_cnt == '0
	);

endmodule

//--- verilog/usb4_lane_codec_top.sv
`timescale 1ns/1ns

module usb4_lane_codec_top (
	input  logic                       enc_clk,
	input  logic                       rst,
	input  logic                       codec_enable,
	input  usb4_link_pkg::gen_speed_t  gen_speed,
	input  usb4_link_pkg::os_sel_t     d_sel,
	input  usb4_block_pkg::lane_pair_t tx_bytes,
	input  logic                       tx_strobe,
	input  logic                       tx_os,
	output usb4_block_pkg::lane_pair_t rx_bytes,
	output logic                       rx_strobe,
	output logic                       data_os,
	output logic                       deskew_enable
);

	import usb4_block_pkg::*;

	// PHY-side loopback between the two block coders
	enc_pair_t blk_words;
	logic      blk_strobe;

	lane_block_encoder u_encoder (
		.enc_clk      (enc_clk),
		.rst          (rst),
		.codec_enable (codec_enable),
		.gen_speed    (gen_speed),
		.tx_bytes     (tx_bytes),
		.tx_strobe    (tx_strobe),
		.tx_os        (tx_os),
		.blk_words    (blk_words),
		.blk_strobe   (blk_strobe)
	);

	lane_block_decoder u_decoder (
		.enc_clk       (enc_clk),
		.rst           (rst),
		.codec_enable  (codec_enable),
		.gen_speed     (gen_speed),
		.d_sel         (d_sel),
		.blk_words     (blk_words),
		.blk_strobe    (blk_strobe),
		.rx_bytes      (rx_bytes),
		.rx_strobe     (rx_strobe),
		.data_os       (data_os),
		.deskew_enable (deskew_enable)
	);

endmodule

//--- bench/codec_checker.sv
`timescale 1ns/1ns

module codec_checker (
	input  logic                       enc_clk,
	input  logic                       rst,
	input  int                         cyc,
	input  usb4_block_pkg::lane_pair_t rx_bytes,
	input  logic                       rx_strobe,
	input  logic                       data_os,
	input  logic                       deskew_enable,
	output int                         errors,
	output int                         pending
);

	import usb4_link_pkg::*;

	// one expected rx beat, tagged with the cycle it has to appear on
	typedef struct packed {
		int         at_cyc;
		lane_byte_t lane_0;
		lane_byte_t lane_1;
		logic       os;
		logic       dsk;
	} exp_beat_t;

	exp_beat_t exp_q[$];

	task automatic push_expected(input int at_cyc, input lane_byte_t l0, input lane_byte_t l1,
			input logic os, input logic dsk);
		exp_beat_t beat;
		beat.at_cyc = at_cyc;
		beat.lane_0 = l0;
		beat.lane_1 = l1;
		beat.os = os;
		beat.dsk = dsk;
		exp_q.push_back(beat);
		pending = exp_q.size();
	endtask

	initial begin
		errors = 0;
		pending = 0;
	end

	always @(posedge enc_clk) begin
		exp_beat_t beat;
		if (rst && rx_strobe) begin
			if (exp_q.size() == 0) begin
				$display("unexpected rx_strobe at cycle %0d with nothing outstanding", cyc);
				errors = errors + 1;
			end else begin
				beat = exp_q.pop_front();
				pending = exp_q.size();
				if (beat.at_cyc != cyc) begin
					$display("rx_strobe came at cycle %0d but was due at cycle %0d", cyc,
						beat.at_cyc);
					errors = errors + 1;
				end
				if (rx_bytes.lane_0 !== beat.lane_0) begin
					$display("FAIL rx_bytes.lane_0 got %h expected %h", rx_bytes.lane_0,
						beat.lane_0);
					errors = errors + 1;
				end
				if (rx_bytes.lane_1 !== beat.lane_1) begin
					$display("FAIL rx_bytes.lane_1 got %h expected %h", rx_bytes.lane_1,
						beat.lane_1);
					errors = errors + 1;
				end
				if (data_os !== beat.os) begin
					$display("FAIL data_os got %h expected %h", data_os, beat.os);
					errors = errors + 1;
				end
				if (deskew_enable !== beat.dsk) begin
					$display("FAIL deskew_enable got %h expected %h", deskew_enable, beat.dsk);
					errors = errors + 1;
				end
			end
		end else if (exp_q.size() != 0 && exp_q[0].at_cyc < cyc) begin
			// the beat never showed up, drop it so later beats still line up
			$display("rx_strobe missing, a beat due at cycle %0d never arrived", exp_q[0].at_cyc);
			errors = errors + 1;
			beat = exp_q.pop_front();
			pending = exp_q.size();
		end
	end

endmodule

//--- bench/tb_usb4_lane_codec.sv
`timescale 1ns/1ns

module tb_usb4_lane_codec;

	import usb4_link_pkg::*;
	import usb4_block_pkg::*;

	// worst case length of all tests in clock cycles
	localparam int STIM_CYCLES = 20 + 20 * 8 + 10 * 16 * 4 + 2 * 20 * 2 + 120 + 60;

	logic       enc_clk;
	logic       rst;
	logic       codec_enable;
	gen_speed_t gen_speed;
	os_sel_t    d_sel;
	lane_pair_t tx_bytes;
	logic       tx_strobe;
	logic       tx_os;
	lane_pair_t rx_bytes;
	logic       rx_strobe;
	logic       data_os;
	logic       deskew_enable;

	int          cyc;
	int          tb_errs;
	int          chk_errs;
	int          pending;
	int          rx_index;
	int          tests_run;
	int          tests_failed;
	int          errs_before;
	logic [31:0] lcg_state;

	usb4_lane_codec_top uut (
		.enc_clk       (enc_clk),
		.rst           (rst),
		.codec_enable  (codec_enable),
		.gen_speed     (gen_speed),
		.d_sel         (d_sel),
		.tx_bytes      (tx_bytes),
		.tx_strobe     (tx_strobe),
		.tx_os         (tx_os),
		.rx_bytes      (rx_bytes),
		.rx_strobe     (rx_strobe),
		.data_os       (data_os),
		.deskew_enable (deskew_enable)
	);

	codec_checker u_check (
		.enc_clk       (enc_clk),
		.rst           (rst),
		.cyc           (cyc),
		.rx_bytes      (rx_bytes),
		.rx_strobe     (rx_strobe),
		.data_os       (data_os),
		.deskew_enable (deskew_enable),
		.errors        (chk_errs),
		.pending       (pending)
	);

	always #20 enc_clk = ~enc_clk;

	always @(posedge enc_clk) begin
		cyc <= cyc + 1;
	end

	function automatic lane_byte_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// loopback returns each byte unchanged; the flag comes from tx_os, or from d_sel in Gen4
	function automatic logic [8:0] expected_lane_byte(input gen_speed_t gen, input logic blk_os,
			input os_sel_t sel, input lane_byte_t tx_b);
		logic flag;
		flag = (gen == GEN4) ? (sel == 4'd8) : blk_os;
		return {flag, tx_b};
	endfunction

	// Gen4 needs a second byte before alignment, blocked modes align on the first
	function automatic logic expected_deskew(input gen_speed_t gen, input int idx);
		return (gen == GEN4) ? (idx >= 1) : 1'b1;
	endfunction

	task automatic send_block(input gen_speed_t gen, input logic os, input int max_gap);
		int         len;
		int         acc;
		int         gap;
		lane_byte_t b0 [16];
		lane_byte_t b1 [16];
		logic [8:0] e0;
		logic [8:0] e1;
		len = (gen == GEN2) ? 8 : (gen == GEN3) ? 16 : 1;
		acc = 0;
		for (int i = 0; i < len; i++) begin
			// random idle cycles in front of each byte
			gap = (max_gap > 0) ? int'(lcg_next()) % (max_gap + 1) : 0;
			for (int g = 0; g < gap; g++) begin
				@(posedge enc_clk);
				tx_strobe <= 1'b0;
			end
			@(posedge enc_clk);
			b0[i] = lcg_next();
			b1[i] = lcg_next();
			tx_bytes <= {b1[i], b0[i]};
			tx_strobe <= 1'b1;
			tx_os <= os;
			// the DUT takes the byte on the next edge
			acc = cyc + 1;
		end
		for (int i = 0; i < len; i++) begin
			e0 = expected_lane_byte(gen, os, d_sel, b0[i]);
			e1 = expected_lane_byte(gen, os, d_sel, b1[i]);
			u_check.push_expected(acc + 2 + i, e0[7:0], e1[7:0], e0[8],
				expected_deskew(gen, rx_index));
			rx_index = rx_index + 1;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge enc_clk);
			tx_strobe <= 1'b0;
		end
	endtask

	// configuration only moves while the codec is disabled
	task automatic set_config(input gen_speed_t gen, input os_sel_t sel);
		@(posedge enc_clk);
		codec_enable <= 1'b0;
		tx_strobe <= 1'b0;
		idle(2);
		@(posedge enc_clk);
		gen_speed <= gen;
		d_sel <= sel;
		@(posedge enc_clk);
		codec_enable <= 1'b1;
		rx_index = 0;
	endtask

	task automatic wait_drain();
		idle(1);
		while (pending != 0) begin
			@(posedge enc_clk);
		end
		idle(2);
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			tb_errs = tb_errs + 1;
		end
	endtask

	task automatic report_test(input string name);
		int errs;
		errs = tb_errs + chk_errs - errs_before;
		tests_run = tests_run + 1;
		if (errs == 0) begin
			$display("test %0d %s: pass", tests_run, name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("test %0d %s: fail with %0d errors", tests_run, name, errs);
		end
		errs_before = tb_errs + chk_errs;
	endtask

	initial begin
		#((STIM_CYCLES + 100) * 40);
		$display("watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		enc_clk = 1'b0;
		rst = 1'b0;
		codec_enable = 1'b0;
		gen_speed = GEN2;
		d_sel = '0;
		tx_bytes = '0;
		tx_strobe = 1'b0;
		tx_os = 1'b0;
		cyc = 0;
		tb_errs = 0;
		rx_index = 0;
		tests_run = 0;
		tests_failed = 0;
		errs_before = 0;
		lcg_state = 32'd14;
		repeat (5) @(posedge enc_clk);
		rst <= 1'b1;

		// strobes while disabled must not reach the receive side
		for (int i = 0; i < 12; i++) begin
			@(posedge enc_clk);
			tx_strobe <= 1'b1;
			tx_bytes <= {lcg_next(), lcg_next()};
			check_level("rx_strobe", rx_strobe, 1'b0);
			check_level("data_os", data_os, 1'b0);
			check_level("deskew_enable", deskew_enable, 1'b0);
		end
		idle(2);
		report_test("reset and disabled");

		set_config(GEN2, '0);
		for (int b = 0; b < 20; b++) begin
			send_block(GEN2, lcg_next() > 8'd127, 0);
		end
		wait_drain();
		report_test("gen2 continuous loopback");

		set_config(GEN3, '0);
		for (int b = 0; b < 10; b++) begin
			send_block(GEN3, lcg_next() > 8'd127, 3);
		end
		wait_drain();
		report_test("gen3 gapped loopback");

		set_config(GEN4, 4'd8);
		for (int b = 0; b < 20; b++) begin
			send_block(GEN4, 1'b0, 0);
		end
		wait_drain();
		set_config(GEN4, 4'd3);
		for (int b = 0; b < 20; b++) begin
			send_block(GEN4, 1'b1, 1);
		end
		wait_drain();
		report_test("gen4 passthrough");

		set_config(GEN2, '0);
		idle(2);
		check_level("deskew_enable", deskew_enable, 1'b0);
		send_block(GEN2, 1'b1, 0);
		wait_drain();
		check_level("deskew_enable", deskew_enable, 1'b1);
		@(posedge enc_clk);
		codec_enable <= 1'b0;
		idle(2);
		check_level("deskew_enable", deskew_enable, 1'b0);
		check_level("data_os", data_os, 1'b0);
		set_config(GEN3, '0);
		send_block(GEN3, 1'b1, 0);
		wait_drain();
		set_config(GEN4, 4'd8);
		for (int b = 0; b < 3; b++) begin
			send_block(GEN4, 1'b0, 0);
		end
		wait_drain();
		report_test("deskew alignment");

		$display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
			tb_errs + chk_errs);
		if (tests_failed == 0 && tb_errs + chk_errs == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
verilog/usb4_link_pkg.sv
verilog/usb4_block_pkg.sv
verilog/lane_block_encoder.sv
verilog/lane_block_decoder.sv
verilog/usb4_lane_codec_top.sv
bench/codec_checker.sv
bench/tb_usb4_lane_codec.sv

//--- run_sim.sh
#!/bin/sh
# builds the lane codec testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f \
	--top-module tb_usb4_lane_codec \
	-o sim_tb_usb4_lane_codec

output=$(./obj_dir/sim_tb_usb4_lane_codec)
echo "$output"

echo "$output" | grep -q "ALL TESTS PASSED"
